//--- dv/match3_input.txt
# keywords: test name, load 8 rows, cmds letters LRUDSN, expect 8 rows then 5 values
# a row is 8 tiles from col 0, 7 is empty; values: row col selected clear_seen tile_ready
test load_no_runs
load 02413024 13024130 24130241 30241302 41302413 02413024 13024130 24130241
expect 02413024 13024130 24130241 30241302 41302413 02413024 13024130 24130241 0 0 0 0 0
test cursor_corner
cmds LLUU
expect 02413024 13024130 24130241 30241302 41302413 02413024 13024130 24130241 0 0 0 0 0
test cursor_right_edge
cmds RRRRRRRR
expect 02413024 13024130 24130241 30241302 41302413 02413024 13024130 24130241 0 7 0 0 0
test select_on
cmds S
expect 02413024 13024130 24130241 30241302 41302413 02413024 13024130 24130241 0 7 1 0 0
test select_blocked_edge
cmds R
expect 02413024 13024130 24130241 30241302 41302413 02413024 13024130 24130241 0 7 0 0 0
test swap_no_run
cmds SL
expect 02413024 13024130 24130241 30241302 41302413 02413024 13024130 24130241 0 7 0 0 0
test new_game
cmds N
expect 77777777 77777777 77777777 77777777 77777777 77777777 77777777 77777777 0 7 0 0 1
test load_with_run
load 02413024 13024130 44430241 30241302 41302413 02413024 13024130 00100241
expect 77713024 02424130 13030241 30241302 41302413 02413024 13024130 00100241 0 7 0 1 0
test swap_run
cmds LLLLLDDDDDDDSR
expect 77713024 77724130 02430241 13041302 30202413 41313024 02424130 13010241 7 2 0 1 0

//--- dv/match3_checks.svh
`ifndef MATCH3_CHECKS_SVH
`define MATCH3_CHECKS_SVH

int              error_count = 0;
int              pass_count  = 0;
int              fail_count  = 0;
int              errors_at_start = 0;
logic [8*24-1:0] test_name;

task automatic check_board(input match3_pkg::board_t expected, input match3_pkg::board_t actual);
    if (actual !== expected) begin
        error_count++;
        // octal, one digit per tile, row 7 col 7 first
        $display("** Error %0s board: expected %o, actual %o", test_name, expected, actual);
    end
endtask

task automatic check_cursor(input match3_pkg::cursor_t expected,
                            input match3_pkg::cursor_t actual);
    if (actual !== expected) begin
        error_count++;
        $display("** Error %0s cursor: expected %0d,%0d, actual %0d,%0d", test_name,
                 expected.row, expected.col, actual.row, actual.col);
    end
endtask

task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
        error_count++;
        $display("** Error %0s %0s: expected %b, actual %b", test_name, what, expected, actual);
    end
endtask

// one line per finished test
task automatic finish_test();
    if (error_count == errors_at_start) begin
        pass_count++;
        $display("%0s: pass", test_name);
    end else begin
        fail_count++;
        $display("%0s: fail", test_name);
    end
endtask

task automatic report_counts();
    $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
endtask

`endif

//--- dv/match3_tb.sv
`include "match3_consts.svh"

module match3_tb;

    logic                clk;
    logic                reset;
    logic                tile_valid;
    logic                tile_ready;
    match3_pkg::tile_t   tile;
    logic                cmd_valid;
    logic                cmd_ready;
    match3_pkg::cmd_t    cmd;
    match3_pkg::board_t  board;
    match3_pkg::cursor_t cursor;
    logic                selected;
    logic                clear_pulse;

    logic timed_out;
    int   fd;
    int   pulse_count = 0;
    int   pulses_at_start = 0;

    `include "match3_checks.svh"

    match3_core dut0 (
        .clk         (clk),
        .reset       (reset),
        .tile_valid  (tile_valid),
        .tile_ready  (tile_ready),
        .tile        (tile),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd         (cmd),
        .board       (board),
        .cursor      (cursor),
        .selected    (selected),
        .clear_pulse (clear_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // clear pulses seen so far
    always @(posedge clk) begin
        if (clear_pulse) begin
            pulse_count <= pulse_count + 1;
        end
    end

    // ----------------------------------------
    // stream and command drivers
    // ----------------------------------------
    task automatic send_tile(input match3_pkg::tile_t t);
        int waited;
        waited     = 0;
        tile_valid = 1'b1;
        tile       = t;
        while (!tile_ready && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (!tile_ready) begin
            $display("timeout: tile_ready stayed low for 500 cycles in %0s", test_name);
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
        end
        tile_valid = 1'b0;
    endtask

    task automatic send_cmd(input match3_pkg::cmd_op_e op);
        int waited;
        waited    = 0;
        cmd_valid = 1'b1;
        cmd.op    = op;
        while (!cmd_ready && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (!cmd_ready) begin
            $display("timeout: cmd_ready stayed low for 500 cycles in %0s", test_name);
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic load_tiles(input match3_pkg::board_t b);
        for (int r = 0; r < `M3_ROWS; r++) begin
            for (int c = 0; c < `M3_COLS; c++) begin
                if (!timed_out) begin
                    send_tile(b[r][c]);
                end
            end
        end
    endtask

    // letters sit right aligned after zero bytes
    task automatic run_cmds(input logic [8*32-1:0] letters);
        logic [7:0] ch;
        for (int i = 31; i >= 0; i--) begin
            ch = letters[8*i +: 8];
            if (ch != 8'd0 && !timed_out) begin
                case (ch)
                    "L": send_cmd(match3_pkg::CMD_LEFT);
                    "R": send_cmd(match3_pkg::CMD_RIGHT);
                    "U": send_cmd(match3_pkg::CMD_UP);
                    "D": send_cmd(match3_pkg::CMD_DOWN);
                    "S": send_cmd(match3_pkg::CMD_SELECT);
                    "N": send_cmd(match3_pkg::CMD_NEW_GAME);
                    default: begin
                        error_count++;
                        $display("unknown command letter %c in %0s", ch, test_name);
                    end
                endcase
            end
        end
    endtask

    // ----------------------------------------
    // data file
    // ----------------------------------------
    task automatic read_board(output match3_pkg::board_t b);
        logic [63:0] row_txt;
        int          n;
        for (int r = 0; r < `M3_ROWS; r++) begin
            n = $fscanf(fd, "%s", row_txt);
            for (int c = 0; c < `M3_COLS; c++) begin
                b[r][c] = match3_pkg::tile_t'(row_txt[8*(7-c) +: 8] - 8'h30);
            end
        end
    endtask

    task automatic run_expect();
        match3_pkg::board_t  exp_board;
        match3_pkg::cursor_t exp_cursor;
        int                  row;
        int                  col;
        int                  sel;
        int                  cleared;
        int                  rdy;
        int                  waited;
        int                  n;
        read_board(exp_board);
        n = $fscanf(fd, "%d %d %d %d %d", row, col, sel, cleared, rdy);
        exp_cursor.row = 3'(row);
        exp_cursor.col = 3'(col);
        waited = 0;
        // settle is over once either port opens again
        while (!(tile_ready || cmd_ready) && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (!(tile_ready || cmd_ready)) begin
            $display("timeout: %0s did not settle within 500 cycles", test_name);
            timed_out = 1'b1;
        end else begin
            check_board(exp_board, board);
            check_cursor(exp_cursor, cursor);
            check_flag("selected", sel[0], selected);
            check_flag("clear_pulse seen", cleared[0], pulse_count != pulses_at_start);
            check_flag("tile_ready", rdy[0], tile_ready);
            // load and play phases never overlap
            check_flag("cmd_ready", !rdy[0], cmd_ready);
            finish_test();
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [8*16-1:0]    word;
        logic [8*128-1:0]   line;
        logic [8*32-1:0]    letters;
        match3_pkg::board_t load_board;
        int                 n;
        reset      = 1'b1;
        tile_valid = 1'b0;
        tile       = '0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        timed_out  = 1'b0;
        test_name  = "reset";
        fd = $fopen("dv/match3_input.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open dv/match3_input.txt");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (fd != 0 && !timed_out) begin
            n = $fscanf(fd, "%s", word);
            if (n != 1) begin
                break;
            end
            case (word)
                "#": n = $fgets(line, fd);
                "test": begin
                    n = $fscanf(fd, "%s", test_name);
                    errors_at_start = error_count;
                    pulses_at_start = pulse_count;
                end
                "load": begin
                    read_board(load_board);
                    load_tiles(load_board);
                end
                "cmds": begin
                    n = $fscanf(fd, "%s", letters);
                    run_cmds(letters);
                end
                "expect": run_expect();
                default: begin
                    error_count++;
                    $display("unknown keyword %0s in the input file", word);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (pass_count + fail_count == 0) begin
            error_count++;
            $display("no test records were read from dv/match3_input.txt");
        end

        report_counts();
        if (error_count == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
+incdir+dv
logic/match3_pkg.sv
logic/match_scan.sv
logic/gravity_step.sv
logic/board_ctrl.sv
logic/match3_core.sv
dv/match3_tb.sv

//--- logic/board_ctrl.sv
`include "match3_consts.svh"

module board_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                tile_valid,
    output logic                tile_ready,
    input  match3_pkg::tile_t   tile,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  match3_pkg::cmd_t    cmd,
    input  match3_pkg::mask_t   live_mask,
    input  match3_pkg::mask_t   trial_mask,
    input  match3_pkg::board_t  fall_board,
    input  logic                falling,
    output match3_pkg::board_t  live_board,
    output match3_pkg::board_t  trial_board,
    output match3_pkg::cursor_t cursor,
    output logic                selected,
    output logic                clear_pulse
);

    localparam match3_pkg::board_t EMPTY_BOARD = {(`M3_ROWS * `M3_COLS){`M3_TILE_EMPTY}};

    match3_pkg::ctrl_state_e state;
    logic [5:0]              load_cnt;

    match3_pkg::cursor_t nb;
    logic                is_dir;
    logic                at_edge;
    logic                swap_keep;

    assign tile_ready  = (state == match3_pkg::S_LOAD);
    assign cmd_ready   = (state == match3_pkg::S_PLAY);
    assign clear_pulse = (state == match3_pkg::S_SETTLE) && (|live_mask);

    // ----------------------------------------
    // neighbour of the cursor for this command
    // ----------------------------------------
    always_comb begin
        nb      = cursor;
        is_dir  = 1'b1;
        at_edge = 1'b0;
        case (cmd.op)
            match3_pkg::CMD_LEFT: begin
                at_edge = (cursor.col == 3'd0);
                nb.col  = cursor.col - 3'd1;
            end
            match3_pkg::CMD_RIGHT: begin
                at_edge = (cursor.col == 3'(`M3_COLS - 1));
                nb.col  = cursor.col + 3'd1;
            end
            match3_pkg::CMD_UP: begin
                at_edge = (cursor.row == 3'd0);
                nb.row  = cursor.row - 3'd1;
            end
            match3_pkg::CMD_DOWN: begin
                at_edge = (cursor.row == 3'(`M3_ROWS - 1));
                nb.row  = cursor.row + 3'd1;
            end
            default: is_dir = 1'b0;
        endcase
    end

    // board as it would look after the swap
    always_comb begin
        trial_board = live_board;
        if (is_dir && !at_edge) begin
            trial_board[cursor.row][cursor.col] = live_board[nb.row][nb.col];
            trial_board[nb.row][nb.col]         = live_board[cursor.row][cursor.col];
        end
    end

    // swap only sticks if one of the moved tiles lands in a run
    assign swap_keep = trial_mask[cursor.row][cursor.col] || trial_mask[nb.row][nb.col];

    // ----------------------------------------
    // main sequencer
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= match3_pkg::S_LOAD;
            live_board <= EMPTY_BOARD;
            cursor     <= '0;
            selected   <= 1'b0;
            load_cnt   <= '0;
        end else begin
            case (state)
                match3_pkg::S_LOAD: begin
                    if (tile_valid) begin
                        // row-major fill
                        live_board[load_cnt[5:3]][load_cnt[2:0]] <= tile;
                        load_cnt <= load_cnt + 6'd1;
                        if (load_cnt == 6'(`M3_ROWS * `M3_COLS - 1)) begin
                            state <= match3_pkg::S_SETTLE;
                        end
                    end
                end

                match3_pkg::S_SETTLE: begin
                    // clear first, then one row of falling per cycle
                    if (|live_mask) begin
                        for (int r = 0; r < `M3_ROWS; r++) begin
                            for (int c = 0; c < `M3_COLS; c++) begin
                                if (live_mask[r][c]) begin
                                    live_board[r][c] <= `M3_TILE_EMPTY;
                                end
                            end
                        end
                    end else if (falling) begin
                        live_board <= fall_board;
                    end else begin
                        state <= match3_pkg::S_PLAY;
                    end
                end

                match3_pkg::S_PLAY: begin
                    if (cmd_valid) begin
                        if (cmd.op == match3_pkg::CMD_NEW_GAME) begin
                            live_board <= EMPTY_BOARD;
                            selected   <= 1'b0;
                            load_cnt   <= '0;
                            state      <= match3_pkg::S_LOAD;
                        end else if (cmd.op == match3_pkg::CMD_SELECT) begin
                            selected <= !selected;
                        end else if (is_dir && !selected) begin
                            if (!at_edge) begin
                                cursor <= nb;
                            end
                        end else if (is_dir) begin
                            // blocked edge still drops the selection
                            selected <= 1'b0;
                            if (!at_edge && swap_keep) begin
                                live_board <= trial_board;
                                state      <= match3_pkg::S_SETTLE;
                            end
                        end
                    end
                end

                default: state <= match3_pkg::S_LOAD;
            endcase
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_one_port_open : assert property (
        @(posedge clk) disable iff (reset) !(tile_ready && cmd_ready)
    ) else $error("tile and command ports open together");

    a_tile_in_range : assert property (
        @(posedge clk) disable iff (reset)
        (tile_valid && tile_ready) |-> (tile < `M3_TILE_KINDS)
    ) else $error("loaded tile code out of range");

    a_cursor_on_board : assert property (
        @(posedge clk) disable iff (reset)
        (state != match3_pkg::S_LOAD) |->
            (cursor.row < `M3_ROWS) && (cursor.col < `M3_COLS)
    ) else $error("cursor left the board");

endmodule

//--- logic/gravity_step.sv
`include "match3_consts.svh"

module gravity_step (
    input  match3_pkg::board_t board,
    output match3_pkg::board_t fall_board,
    output logic               falling
);

    always_comb begin
        logic above;
        logic found;
        int   hole;
        fall_board = board;
        falling    = 1'b0;

        for (int c = 0; c < `M3_COLS; c++) begin
            above = 1'b0;
            found = 1'b0;
            hole  = 0;

            // lowest hole with a tile somewhere over it
            for (int r = 0; r < `M3_ROWS; r++) begin
                if (board[r][c] == `M3_TILE_EMPTY) begin
                    if (above) begin
                        found = 1'b1;
                        hole  = r;
                    end
                end else begin
                    above = 1'b1;
                end
            end

            // shift everything above the hole down one row
            if (found) begin
                falling          = 1'b1;
                fall_board[0][c] = `M3_TILE_EMPTY;
                for (int r = 1; r < `M3_ROWS; r++) begin
                    if (r <= hole) begin
                        fall_board[r][c] = board[r-1][c];
                    end
                end
            end
        end
    end

    // a settled column must come back untouched
    a_still_when_not_falling : assert property (
        @(board) !falling |-> (fall_board == board)
    ) else $error("gravity_step changed a board with nothing falling");

endmodule

//--- logic/match3_consts.svh
`ifndef MATCH3_CONSTS_SVH
`define MATCH3_CONSTS_SVH

// board geometry
`define M3_ROWS 8
`define M3_COLS 8

// tile encoding
`define M3_TILE_W 3
`define M3_TILE_EMPTY 3'd7
// valid tiles are 0 .. kinds-1
`define M3_TILE_KINDS 5

// shortest line that clears
`define M3_RUN_LEN 3

`endif

//--- logic/match3_core.sv
module match3_core (
    input  logic                clk,
    input  logic                reset,
    // tile stream
    input  logic                tile_valid,
    output logic                tile_ready,
    input  match3_pkg::tile_t   tile,
    // command port
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  match3_pkg::cmd_t    cmd,
    // game state
    output match3_pkg::board_t  board,
    output match3_pkg::cursor_t cursor,
    output logic                selected,
    output logic                clear_pulse
);

    match3_pkg::board_t trial_board;
    match3_pkg::board_t fall_board;
    match3_pkg::mask_t  live_mask;
    match3_pkg::mask_t  trial_mask;
    logic               falling;

    board_ctrl ctrl0 (
        .clk         (clk),
        .reset       (reset),
        .tile_valid  (tile_valid),
        .tile_ready  (tile_ready),
        .tile        (tile),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd         (cmd),
        .live_mask   (live_mask),
        .trial_mask  (trial_mask),
        .fall_board  (fall_board),
        .falling     (falling),
        .live_board  (board),
        .trial_board (trial_board),
        .cursor      (cursor),
        .selected    (selected),
        .clear_pulse (clear_pulse)
    );

    // runs on the board as it stands
    match_scan scan_live (
        .board (board),
        .mask  (live_mask)
    );

    // runs after the proposed swap
    match_scan scan_trial (
        .board (trial_board),
        .mask  (trial_mask)
    );

    gravity_step gravity0 (
        .board      (board),
        .fall_board (fall_board),
        .falling    (falling)
    );

endmodule

//--- logic/match3_pkg.sv
`include "match3_consts.svh"

package match3_pkg;

    // ----------------------------------------
    // board data
    // ----------------------------------------

    typedef logic [`M3_TILE_W-1:0] tile_t;

    // row 0 is the top row, board[row][col]
    typedef tile_t [`M3_ROWS-1:0][`M3_COLS-1:0] board_t;

    // one bit per cell, set where a run covers it
    typedef logic [`M3_ROWS-1:0][`M3_COLS-1:0] mask_t;

    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } cursor_t;

    // ----------------------------------------
    // commands and control
    // ----------------------------------------

    typedef enum logic [2:0] {
        CMD_LEFT,
        CMD_RIGHT,
        CMD_UP,
        CMD_DOWN,
        CMD_SELECT,
        CMD_NEW_GAME
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e op;
    } cmd_t;

    typedef enum logic [1:0] {
        S_LOAD,
        S_SETTLE,
        S_PLAY
    } ctrl_state_e;

endpackage

//--- logic/match_scan.sv
`include "match3_consts.svh"

module match_scan (
    input  match3_pkg::board_t board,
    output match3_pkg::mask_t  mask
);

    always_comb begin
        logic run;
        mask = '0;

        // ----------------------------------------
        // horizontal windows
        // ----------------------------------------
        for (int r = 0; r < `M3_ROWS; r++) begin
            for (int c = 0; c <= `M3_COLS - `M3_RUN_LEN; c++) begin
                run = (board[r][c] != `M3_TILE_EMPTY);
                for (int k = 1; k < `M3_RUN_LEN; k++) begin
                    run = run && (board[r][c+k] == board[r][c]);
                end
                // longer runs are covered by overlapping windows
                if (run) begin
                    for (int k = 0; k < `M3_RUN_LEN; k++) begin
                        mask[r][c+k] = 1'b1;
                    end
                end
            end
        end

        // ----------------------------------------
        // vertical windows
        // ----------------------------------------
        for (int r = 0; r <= `M3_ROWS - `M3_RUN_LEN; r++) begin
            for (int c = 0; c < `M3_COLS; c++) begin
                run = (board[r][c] != `M3_TILE_EMPTY);
                for (int k = 1; k < `M3_RUN_LEN; k++) begin
                    run = run && (board[r+k][c] == board[r][c]);
                end
                if (run) begin
                    for (int k = 0; k < `M3_RUN_LEN; k++) begin
                        mask[r+k][c] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the match3 testbench with Verilator, run it, then search the log for the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module match3_tb \
    -o match3_sim && ./obj_dir/match3_sim | tee sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
